/* rtl/iccm_data_pkg.sv */
// ICCM datapath types
// Bank words are opaque, ECC is generated and checked outside the memory
package iccm_data_pkg;

   // One bank word, 32 data bits plus 7 ECC bits
   typedef logic [38:0] bank_word_t;

   // Two bank words, lower word in the low bits
   typedef logic [77:0] wide_word_t;

   // Halfword aligned read data towards fetch
   typedef logic [63:0] rd_data_t;

   // Data part of a bank word, ECC sits above it
   localparam int WORD_DATA_BITS = 32;

endpackage

/* rtl/iccm_map_pkg.sv */
// ICCM bank map and access size encoding
// Word address bits [3:2] pick the bank, the rest index the row
package iccm_map_pkg;

   // ****************************************
   // Bank organisation
   // ****************************************

   // Fixed, the redundancy match and the bank field assume four banks
   localparam int NUM_BANKS = 4;

   typedef logic [1:0] bank_sel_t;   // Bank number
   typedef logic [3:0] bank_vec_t;   // One bit per bank

   // ****************************************
   // Access size
   // ****************************************

   typedef logic [2:0] acc_size_t;   // Byte/half/word/double

   // Low two size bits for a double word
   localparam logic [1:0] SIZE_DW = 2'd3;

endpackage

/* rtl/iccm_access_decode.sv */
// ICCM access decode
// Second word address, per-bank enables, rows and write lanes
`timescale 1ns/1ps

module iccm_access_decode
   import iccm_data_pkg::*;
   import iccm_map_pkg::*;
#(
   parameter int INDEX_BITS = 6,
   localparam int ADDR_BITS = INDEX_BITS + 4
) (
   input  logic [ADDR_BITS-1:1]                  rw_addr,      // Halfword address
   input  acc_size_t                             wr_size,
   input  wide_word_t                            wr_data,
   input  logic                                  wren,
   input  logic                                  rden,
   output logic [ADDR_BITS-1:1]                  addr_inc,     // Address of the following word
   output bank_vec_t                             bank_wren,
   output bank_vec_t                             bank_rden,
   output logic [NUM_BANKS-1:0][INDEX_BITS-1:0]  bank_row,
   output bank_word_t [NUM_BANKS-1:0]            bank_wr_data
);

   localparam int WORD_BITS = $bits(bank_word_t);

   logic [1:0] addr_step;
   bank_sel_t  bank_lo;                    // Bank of rw_addr
   bank_sel_t  bank_hi;                    // Bank of addr_inc

   // ****************************************
   // Second address
   // ****************************************

   // DW steps a whole word (two halfwords), anything else a single halfword
   assign addr_step = (wr_size[1:0] == SIZE_DW) ? 2'd2 : 2'd1;
   assign addr_inc  = rw_addr + {{(ADDR_BITS-3){1'b0}}, addr_step};

   assign bank_lo = rw_addr[3:2];
   assign bank_hi = addr_inc[3:2];

   // ****************************************
   // Per-bank steering
   // ****************************************

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      logic bank_hit;                      // Either address lands here
      logic inc_hit;                       // Second address lands here

      assign inc_hit  = (bank_hi == bank_sel_t'(i));
      assign bank_hit = (bank_lo == bank_sel_t'(i)) | inc_hit;

      assign bank_wren[i] = wren & bank_hit;
      assign bank_rden[i] = rden & bank_hit;

      // Writes are aligned, so the row of rw_addr serves both banks
      // Reads wrapping into the next row take it from addr_inc
      assign bank_row[i] = (wren | ~inc_hit) ? rw_addr[ADDR_BITS-1:4]
                                             : addr_inc[ADDR_BITS-1:4];

      // Even banks get the lower word, odd banks the upper
      assign bank_wr_data[i] = wr_data[WORD_BITS*(i%2) +: WORD_BITS];
   end

endmodule

/* rtl/iccm_bank_array.sv */
// ICCM bank array
// Four behavioural single-port RAMs, synchronous read, output held between reads
`timescale 1ns/1ps

module iccm_bank_array
   import iccm_data_pkg::*;
   import iccm_map_pkg::*;
#(
   parameter int INDEX_BITS = 6
) (
   input  logic                                  clk,
   input  bank_vec_t                             bank_wren,
   input  bank_vec_t                             bank_rden,
   input  logic [NUM_BANKS-1:0][INDEX_BITS-1:0]  bank_row,
   input  bank_word_t [NUM_BANKS-1:0]            bank_wr_data,
   output bank_word_t [NUM_BANKS-1:0]            bank_dout
);

   localparam int DEPTH = 1 << INDEX_BITS;    // Rows per bank

   // ****************************************
   // Bank RAMs
   // ****************************************

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_ram
      bank_word_t mem [DEPTH];                // Storage, contents survive reset
      bank_word_t dout_q;                     // Read register

      // Write and read never come together on one bank
      always_ff @(posedge clk) begin
         if (bank_wren[i]) begin
            mem[bank_row[i]] <= bank_wr_data[i];
         end
         else if (bank_rden[i]) begin
            dout_q <= mem[bank_row[i]];       // Data valid the cycle after
         end
      end

      assign bank_dout[i] = dout_q;           // Holds while bank idle
   end

endmodule

/* rtl/iccm_redundancy.sv */
// ICCM redundant rows
// Two spare words stand in for faulty locations, replaced by a one-bit LRU
`timescale 1ns/1ps

module iccm_redundancy
   import iccm_data_pkg::*;
   import iccm_map_pkg::*;
#(
   parameter int INDEX_BITS = 6,
   localparam int ADDR_BITS = INDEX_BITS + 4
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [ADDR_BITS-1:1] rw_addr,
   input  logic [ADDR_BITS-1:1] addr_inc,
   input  acc_size_t            wr_size,
   input  wide_word_t           wr_data,
   input  logic                 wren,
   input  logic                 rden,
   input  logic                 buf_correct_ecc,     // Correction write, word sized
   input  logic                 correction_state,    // Reads belong to a correction
   output bank_vec_t            sel_red0_q,          // Row 0 replaces these banks
   output bank_vec_t            sel_red1_q,          // Row 1 replaces these banks
   output bank_word_t           red_data0,
   output bank_word_t           red_data1
);

   localparam int WORD_BITS = $bits(bank_word_t);

   logic [ADDR_BITS-1:2] red_addr [2];       // Word address per row
   logic                 red_valid [2];
   bank_word_t           red_data [2];
   bank_vec_t            sel_red [2];
   bank_vec_t            sel_red_q [2];
   logic [1:0]           capture;            // Correction lands in this row
   logic [1:0]           wr_hit;             // Normal write covers this row
   logic [1:0]           rd_hit;             // Any bank matched this row
   logic                 size_dw;
   logic                 red_lru;            // Next row to replace
   logic                 red_lru_en;
   logic                 red_lru_in;

   assign size_dw = (wr_size[1:0] == SIZE_DW);

   // ****************************************
   // Per-row match and hit
   // ****************************************

   for (genvar r = 0; r < 2; r++) begin : g_row
      assign capture[r] = buf_correct_ecc & (red_lru == 1'(r));

      // Either word of the access may fall on the faulty location
      for (genvar i = 0; i < NUM_BANKS; i++) begin : g_match
         assign sel_red[r][i] = red_valid[r] &
            (((rw_addr[ADDR_BITS-1:2] == red_addr[r]) & (rw_addr[3:2] == bank_sel_t'(i))) |
             ((addr_inc[ADDR_BITS-1:2] == red_addr[r]) & (addr_inc[3:2] == bank_sel_t'(i))));
      end

      // DW writes cover both words of the double word
      assign wr_hit[r] = wren & red_valid[r] &
                         (rw_addr[ADDR_BITS-1:3] == red_addr[r][ADDR_BITS-1:3]) &
                         ((rw_addr[2] == red_addr[r][2]) | size_dw);

      assign rd_hit[r] = |sel_red[r];
   end

   // ****************************************
   // LRU
   // ****************************************

   // Correction flips it, a hit during correction points it away from the hit row
   assign red_lru_en = buf_correct_ecc | ((|rd_hit) & rden & correction_state);
   assign red_lru_in = buf_correct_ecc ? ~red_lru : rd_hit[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         red_lru <= 1'b0;
      end
      else if (red_lru_en) begin
         red_lru <= red_lru_in;
      end
   end

   // ****************************************
   // Row state
   // ****************************************

   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (reset) begin
            red_valid[r] <= 1'b0;
            red_addr[r]  <= '0;
            sel_red_q[r] <= '0;
         end
         else begin
            sel_red_q[r] <= sel_red[r];          // Loads every cycle
            if (capture[r]) begin
               red_valid[r] <= 1'b1;
               red_addr[r]  <= rw_addr[ADDR_BITS-1:2];
            end
         end
      end
   end

   // Correction data is splat on both halves, lower word taken
   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (capture[r]) begin
            red_data[r] <= wr_data[WORD_BITS-1:0];
         end
         else if (wr_hit[r]) begin
            red_data[r] <= red_addr[r][2] ? wr_data[2*WORD_BITS-1:WORD_BITS]
                                          : wr_data[WORD_BITS-1:0];   // Odd word from upper
         end
      end
   end

   assign sel_red0_q = sel_red_q[0];
   assign sel_red1_q = sel_red_q[1];
   assign red_data0  = red_data[0];
   assign red_data1  = red_data[1];

endmodule

/* rtl/iccm_read_align.sv */
// ICCM read alignment
// Swaps in redundant words, picks low and high banks, aligns to the halfword
`timescale 1ns/1ps

module iccm_read_align
   import iccm_data_pkg::*;
   import iccm_map_pkg::*;
#(
   parameter int INDEX_BITS = 6,
   localparam int ADDR_BITS = INDEX_BITS + 4
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [ADDR_BITS-1:1]       rw_addr,
   input  logic [ADDR_BITS-1:1]       addr_inc,
   input  bank_word_t [NUM_BANKS-1:0] bank_dout,
   input  bank_vec_t                  sel_red0_q,
   input  bank_vec_t                  sel_red1_q,
   input  bank_word_t                 red_data0,
   input  bank_word_t                 red_data1,
   output rd_data_t                   rd_data,
   output wide_word_t                 rd_data_ecc
);

   localparam int PAIR_BITS = 2 * WORD_DATA_BITS;

   bank_word_t [NUM_BANKS-1:0] dout_fn;        // Bank data after substitution
   bank_sel_t                  lo_bank_q;
   bank_sel_t                  hi_bank_q;
   logic                       lo_half_q;      // Request started on odd halfword
   bank_word_t                 lo_word;
   bank_word_t                 hi_word;
   logic [PAIR_BITS-1:0]       rd_pre;
   logic [PAIR_BITS-1:0]       rd_shift;

   // Row 1 wins if both rows claim a bank
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_sub
      assign dout_fn[i] = sel_red1_q[i] ? red_data1 :
                          sel_red0_q[i] ? red_data0 : bank_dout[i];
   end

   // Bank numbers line up with the RAM output a cycle later
   always_ff @(posedge clk) begin
      if (reset) begin
         lo_bank_q <= '0;
         hi_bank_q <= '0;
         lo_half_q <= 1'b0;
      end
      else begin
         lo_bank_q <= rw_addr[3:2];
         hi_bank_q <= addr_inc[3:2];
         lo_half_q <= rw_addr[1];
      end
   end

   assign lo_word     = dout_fn[lo_bank_q];
   assign hi_word     = dout_fn[hi_bank_q];
   assign rd_data_ecc = {hi_word, lo_word};   // Raw words incl. ECC

   assign rd_pre   = {hi_word[WORD_DATA_BITS-1:0], lo_word[WORD_DATA_BITS-1:0]};
   assign rd_shift = lo_half_q ? (rd_pre >> 16) : rd_pre;
   assign rd_data  = {16'h0, rd_shift[PAIR_BITS-17:0]};   // Top halfword always zero

endmodule

/* rtl/iccm_mem.sv */
// ICCM top level
// Four interleaved banks of 39-bit words with two redundant rows
`timescale 1ns/1ps

module iccm_mem
   import iccm_data_pkg::*;
   import iccm_map_pkg::*;
#(
   parameter int INDEX_BITS = 6,
   localparam int ADDR_BITS = INDEX_BITS + 4
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 wren,
   input  logic                 rden,
   input  logic [ADDR_BITS-1:1] rw_addr,
   input  acc_size_t            wr_size,
   input  wide_word_t           wr_data,
   input  logic                 buf_correct_ecc,
   input  logic                 correction_state,
   output rd_data_t             rd_data,            // Valid the cycle after rden
   output wide_word_t           rd_data_ecc
);

   logic [ADDR_BITS-1:1]                 addr_inc;
   bank_vec_t                            bank_wren;
   bank_vec_t                            bank_rden;
   logic [NUM_BANKS-1:0][INDEX_BITS-1:0] bank_row;
   bank_word_t [NUM_BANKS-1:0]           bank_wr_data;
   bank_word_t [NUM_BANKS-1:0]           bank_dout;
   bank_vec_t                            sel_red0_q;
   bank_vec_t                            sel_red1_q;
   bank_word_t                           red_data0;
   bank_word_t                           red_data1;

   iccm_access_decode #(.INDEX_BITS(INDEX_BITS)) u_decode (
      .rw_addr(rw_addr), .wr_size(wr_size), .wr_data(wr_data),
      .wren(wren), .rden(rden), .addr_inc(addr_inc),
      .bank_wren(bank_wren), .bank_rden(bank_rden),
      .bank_row(bank_row), .bank_wr_data(bank_wr_data)
   );

   iccm_bank_array #(.INDEX_BITS(INDEX_BITS)) u_banks (
      .clk(clk), .bank_wren(bank_wren), .bank_rden(bank_rden),
      .bank_row(bank_row), .bank_wr_data(bank_wr_data), .bank_dout(bank_dout)
   );

   iccm_redundancy #(.INDEX_BITS(INDEX_BITS)) u_redundancy (
      .clk(clk), .reset(reset), .rw_addr(rw_addr), .addr_inc(addr_inc),
      .wr_size(wr_size), .wr_data(wr_data), .wren(wren), .rden(rden),
      .buf_correct_ecc(buf_correct_ecc), .correction_state(correction_state),
      .sel_red0_q(sel_red0_q), .sel_red1_q(sel_red1_q),
      .red_data0(red_data0), .red_data1(red_data1)
   );

   iccm_read_align #(.INDEX_BITS(INDEX_BITS)) u_align (
      .clk(clk), .reset(reset), .rw_addr(rw_addr), .addr_inc(addr_inc),
      .bank_dout(bank_dout), .sel_red0_q(sel_red0_q), .sel_red1_q(sel_red1_q),
      .red_data0(red_data0), .red_data1(red_data1),
      .rd_data(rd_data), .rd_data_ecc(rd_data_ecc)
   );

endmodule

/* testbench/iccm_mem_chk.sv */
// ICCM protocol assertions
// Strobe exclusivity, correction size and the zero top halfword of read data
`timescale 1ns/1ps

module iccm_mem_chk
   import iccm_data_pkg::*;
   import iccm_map_pkg::*;
(
   input logic      clk,
   input logic      reset,
   input logic      wren,
   input logic      rden,
   input acc_size_t wr_size,
   input logic      buf_correct_ecc,
   input rd_data_t  rd_data
);

   localparam logic [1:0] SIZE_WORD = 2'd2;   // Low size bits of a word access

   // ****************************************
   // Request side
   // ****************************************

   a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(wren && rden))
      else $error("wren and rden high in the same cycle");

   a_corr_word: assert property (@(posedge clk) disable iff (reset)
      buf_correct_ecc |-> (wr_size[1:0] == SIZE_WORD))
      else $error("correction cycle without word size");

   // Fetch data is 48 bits wide at most
   a_rd_top_zero: assert property (@(posedge clk) disable iff (reset)
      rden |=> (rd_data[63:48] == 16'h0))
      else $error("rd_data top halfword not zero after a read");

endmodule

bind iccm_mem iccm_mem_chk chk0 (
   .clk(clk), .reset(reset), .wren(wren), .rden(rden), .wr_size(wr_size),
   .buf_correct_ecc(buf_correct_ecc), .rd_data(rd_data)
);

/* testbench/tb_iccm_mem.sv */
// ICCM testbench
// Directed and random accesses against a bank and redundant-row model
`timescale 1ns/1ps

module tb_iccm_mem
   import iccm_data_pkg::*;
   import iccm_map_pkg::*;
();

   localparam int INDEX_BITS = 6;
   localparam int ADDR_BITS  = INDEX_BITS + 4;
   localparam int WA_BITS    = ADDR_BITS - 2;          // Word address width
   localparam int N_DW       = 16;
   localparam int N_RAND     = 400;
   localparam int TOTAL_OPS  = 10 + 3 * N_DW + 20 + N_RAND;
   localparam acc_size_t SZ_WORD = 3'd2;
   localparam acc_size_t SZ_DW   = {1'b0, SIZE_DW};

   typedef logic [WA_BITS-1:0] waddr_t;

   logic                 clk = 1'b0;
   logic                 reset;
   logic                 wren;
   logic                 rden;
   logic [ADDR_BITS-1:1] rw_addr;
   acc_size_t            wr_size;
   wide_word_t           wr_data;
   logic                 buf_correct_ecc;
   logic                 correction_state;
   rd_data_t             rd_data;
   wide_word_t           rd_data_ecc;

   // Reference model with banks picked by word address bits [1:0]
   bank_word_t m_bank [NUM_BANKS][1 << INDEX_BITS];
   bit         m_written [NUM_BANKS][1 << INDEX_BITS];
   bank_word_t m_red_data [2];
   waddr_t     m_red_addr [2];
   bit         m_red_valid [2] = '{1'b0, 1'b0};
   bit         m_lru = 1'b0;                    // Row taken by next correction
   waddr_t     written_q [$];                   // Bank words safe to read

   bit         pend = 1'b0;                     // Read result due this cycle
   wide_word_t exp_ecc;
   rd_data_t   exp_rd;
   wide_word_t last_ecc;
   int         t_checks = 0;
   int         t_errors = 0;
   int         checks = 0;
   int         errors = 0;

   iccm_mem #(.INDEX_BITS(INDEX_BITS)) dut0 (
      .clk(clk), .reset(reset), .wren(wren), .rden(rden), .rw_addr(rw_addr),
      .wr_size(wr_size), .wr_data(wr_data), .buf_correct_ecc(buf_correct_ecc),
      .correction_state(correction_state), .rd_data(rd_data), .rd_data_ecc(rd_data_ecc)
   );

   always #50 clk = ~clk;                       // 100 ns period

   initial begin
      #(TOTAL_OPS * 100 * 4);
      $display("watchdog expired, the tests did not complete in time");
      $display("*** FAILED ***");
      $finish;
   end

   // ****************************************
   // Model helpers
   // ****************************************

   function automatic bank_word_t rand_word();
      return bank_word_t'({$urandom, $urandom});
   endfunction

   function automatic bit red_hit(int r, waddr_t wa);
      return m_red_valid[r] && (m_red_addr[r] == wa);
   endfunction

   // Row 1 wins when both rows hold the word
   function automatic bank_word_t model_word(waddr_t wa);
      if (red_hit(1, wa)) return m_red_data[1];
      if (red_hit(0, wa)) return m_red_data[0];
      return m_bank[wa[1:0]][wa[WA_BITS-1:2]];
   endfunction

   function automatic bit is_known(waddr_t wa);
      return m_written[wa[1:0]][wa[WA_BITS-1:2]] || red_hit(0, wa) || red_hit(1, wa);
   endfunction

   // Word reached by stepping one halfword or two for DW
   function automatic waddr_t next_word(waddr_t wa, bit half, bit dw);
      logic [ADDR_BITS-1:1] inc;
      inc = {wa, half} + (ADDR_BITS-1)'(dw ? 2 : 1);
      return inc[ADDR_BITS-1:2];
   endfunction

   function automatic void store_word(waddr_t wa, bank_word_t w);
      if (!m_written[wa[1:0]][wa[WA_BITS-1:2]]) begin
         written_q.push_back(wa);
      end
      m_written[wa[1:0]][wa[WA_BITS-1:2]] = 1'b1;
      m_bank[wa[1:0]][wa[WA_BITS-1:2]] = w;
   endfunction

   // ****************************************
   // Bus tasks start and end on a falling edge
   // ****************************************

   task automatic next_cycle();
      @(negedge clk);
      if (pend) begin
         t_checks++;
         last_ecc = rd_data_ecc;
         if (rd_data_ecc !== exp_ecc || rd_data !== exp_rd) begin
            t_errors++;
            $display("FAILED %0t: read ecc %h data %h, expected %h %h",
                     $time, rd_data_ecc, rd_data, exp_ecc, exp_rd);
         end
         pend = 1'b0;
      end
      wren             = 1'b0;             // Back to idle unless driven again
      rden             = 1'b0;
      buf_correct_ecc  = 1'b0;
      correction_state = 1'b0;
   endtask

   task automatic write_access(waddr_t wa, bit dw, bank_word_t lo, bank_word_t hi);
      rw_addr = {wa, 1'b0};
      wr_size = dw ? SZ_DW : SZ_WORD;
      wr_data = {hi, lo};
      wren    = 1'b1;
      for (int r = 0; r < 2; r++) begin
         if (m_red_valid[r] && m_red_addr[r][WA_BITS-1:1] == wa[WA_BITS-1:1] &&
             (m_red_addr[r][0] == wa[0] || dw)) begin
            m_red_data[r] = m_red_addr[r][0] ? hi : lo;   // Odd word from upper half
         end
      end
      if (dw) begin
         store_word(wa, lo);
         store_word(wa | waddr_t'(1), hi);
      end
      else begin
         store_word(wa, wa[0] ? hi : lo);
      end
      next_cycle();
   endtask

   task automatic correct_word(waddr_t wa, bank_word_t w, bit we);
      bit r;
      r = m_lru;
      rw_addr         = {wa, 1'b0};
      wr_size         = SZ_WORD;
      wr_data         = {w, w};
      wren            = we;
      buf_correct_ecc = 1'b1;
      if (we) begin
         store_word(wa, w);
         if (red_hit(int'(!r), wa)) begin
            m_red_data[!r] = w;                   // Other row refreshed by the write
         end
      end
      m_red_valid[r] = 1'b1;
      m_red_addr[r]  = wa;
      m_red_data[r]  = w;
      m_lru          = !m_lru;
      next_cycle();
   endtask

   task automatic read_access(waddr_t wa, bit half, bit dw, bit corr);
      waddr_t      wa1;
      bank_word_t  lo;
      bank_word_t  hi;
      logic [63:0] pre;
      wa1 = next_word(wa, half, dw);
      lo  = model_word(wa);
      hi  = model_word(wa1);
      pre = {hi[WORD_DATA_BITS-1:0], lo[WORD_DATA_BITS-1:0]};
      if (half) begin
         pre = pre >> 16;
      end
      exp_ecc = {hi, lo};
      exp_rd  = {16'h0, pre[47:0]};
      if (corr && (red_hit(0, wa) || red_hit(0, wa1))) begin
         m_lru = 1'b1;
      end
      else if (corr && (red_hit(1, wa) || red_hit(1, wa1))) begin
         m_lru = 1'b0;
      end
      rw_addr          = {wa, half};
      wr_size          = dw ? SZ_DW : SZ_WORD;
      wr_data          = '0;
      rden             = 1'b1;
      correction_state = corr;
      pend             = 1'b1;
      next_cycle();
   endtask

   task automatic expect_word(bank_word_t got, bank_word_t want, string what);
      t_checks++;
      if (got !== want) begin
         t_errors++;
         $display("FAILED %0t: %s got %h expected %h", $time, what, got, want);
      end
   endtask

   task automatic end_test(string name);
      $display("test %s: %0d checks, %0d errors", name, t_checks, t_errors);
      checks += t_checks;
      errors += t_errors;
      t_checks = 0;
      t_errors = 0;
   endtask

   // ****************************************
   // Test sequence
   // ****************************************

   initial begin
      int unsigned op;
      waddr_t      wa;
      waddr_t      dw_list [$];
      bank_word_t  w0;
      bank_word_t  w1;
      bank_word_t  bw;
      bit          hb;
      bit          dwb;
      void'($urandom(32'hdf0e0fb3));
      reset = 1'b1;
      wren = 1'b0;
      rden = 1'b0;
      rw_addr = '0;
      wr_size = SZ_WORD;
      wr_data = '0;
      buf_correct_ecc = 1'b0;
      correction_state = 1'b0;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      // One aligned double word per 16-word slice
      for (int i = 0; i < N_DW; i++) begin
         wa = waddr_t'(i * 16 + 2 * ($urandom % 8));
         dw_list.push_back(wa);
         write_access(wa, 1'b1, rand_word(), rand_word());
      end
      foreach (dw_list[i]) read_access(dw_list[i], 1'b0, 1'b1, 1'b0);
      end_test("dw_write_read");

      foreach (dw_list[i]) read_access(dw_list[i], 1'b1, 1'($urandom), 1'b0);
      end_test("halfword_align");

      wa = dw_list[0];
      w0 = rand_word();
      correct_word(wa, w0, 1'b0);                 // Bank keeps its old word
      read_access(wa, 1'b0, 1'b0, 1'b0);
      expect_word(last_ecc[38:0], w0, "corrected word");
      bw = m_bank[wa[1:0] + 2'd1][wa[WA_BITS-1:2]];
      read_access(wa + waddr_t'(1), 1'b0, 1'b0, 1'b0);
      expect_word(last_ecc[38:0], bw, "neighbour word");
      end_test("correction_install");

      w1 = rand_word();
      write_access(wa, 1'b0, w1, w1);
      read_access(wa, 1'b0, 1'b0, 1'b0);
      expect_word(last_ecc[38:0], w1, "row after write");
      end_test("write_hits_row");

      // Row 0 holds wa and the LRU points at row 1
      correct_word(dw_list[1], rand_word(), 1'b0);
      correct_word(dw_list[2], rand_word(), 1'b0);  // Evicts wa
      read_access(wa, 1'b0, 1'b0, 1'b0);
      expect_word(last_ecc[38:0], w1, "bank after write");
      correct_word(dw_list[3], rand_word(), 1'b0);  // Evicts dw_list[1]
      read_access(dw_list[1], 1'b0, 1'b0, 1'b0);
      bw = m_bank[dw_list[1][1:0]][dw_list[1][WA_BITS-1:2]];
      expect_word(last_ecc[38:0], bw, "evicted word");
      bw = m_red_data[0];
      read_access(dw_list[2], 1'b0, 1'b0, 1'b1);  // Protects row 0
      correct_word(dw_list[4], rand_word(), 1'b0);
      read_access(dw_list[2], 1'b0, 1'b0, 1'b0);
      expect_word(last_ecc[38:0], bw, "protected row");
      read_access(dw_list[3], 1'b0, 1'b0, 1'b0);
      end_test("lru_replace");

      for (int i = 0; i < N_RAND; i++) begin
         op = $urandom % 100;
         if (op < 25) begin
            write_access({(WA_BITS-1)'($urandom), 1'b0}, 1'b1, rand_word(), rand_word());
         end
         else if (op < 40) begin
            w0 = rand_word();
            write_access(waddr_t'($urandom), 1'b0, w0, w0);
         end
         else if (op < 48) begin
            correct_word(waddr_t'($urandom), rand_word(), 1'($urandom));
         end
         else begin
            wa  = written_q[$urandom % written_q.size()];
            hb  = 1'($urandom);
            dwb = 1'($urandom);
            if (!is_known(next_word(wa, hb, dwb))) begin
               hb  = 1'b0;                        // Same word twice
               dwb = 1'b0;
            end
            read_access(wa, hb, dwb, 1'($urandom));
         end
      end
      end_test("random_mix");

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end
      else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* filelist.f */
rtl/iccm_data_pkg.sv
rtl/iccm_map_pkg.sv
rtl/iccm_access_decode.sv
rtl/iccm_bank_array.sv
rtl/iccm_redundancy.sv
rtl/iccm_read_align.sv
rtl/iccm_mem.sv
testbench/iccm_mem_chk.sv
testbench/tb_iccm_mem.sv

/* run.sh */
#!/bin/sh
# Build the ICCM testbench with Verilator, run it and look for the pass line
verilator --binary --assert --top-module tb_iccm_mem -f filelist.f \
   -Mdir obj_dir -o sim_iccm \
   && ./obj_dir/sim_iccm | grep -F "*** PASSED ***" \
   || { echo "ICCM simulation did not pass"; exit 1; }
